//--- src/icache_pkg.sv
package icache_pkg;

   // Address layout of the cache
   localparam int ADDR_W    = 32;
   localparam int LINE_LOG2 = 5;
   localparam int SETS_LOG2 = 6;
   localparam int WORD_LOG2 = 3;

   localparam int TAG_W = ADDR_W - SETS_LOG2 - LINE_LOG2;

   // Windows per line, which is also the burst length
   localparam int BEAT_W = LINE_LOG2 - WORD_LOG2;
   localparam int BEATS  = 1 << BEAT_W;

   localparam int FETCH_W    = 8 << WORD_LOG2;
   localparam int PAYLOAD_AW = SETS_LOG2 + BEAT_W;

   // Two instructions, one bus beat
   typedef logic [FETCH_W-1:0] fetch_word_t;

   typedef logic [TAG_W-1:0] tag_t;

   // Tag in the upper bits, valid flag in bit 0
   typedef logic [TAG_W:0] tag_entry_t;

   // Same address seen by the tag RAM and by the payload RAM
   typedef union packed {
      struct packed {
         tag_t                 tag;
         logic [SETS_LOG2-1:0] set_idx;
         logic [LINE_LOG2-1:0] offset;
      } lk;
      struct packed {
         tag_t                  tag;
         logic [PAYLOAD_AW-1:0] word;
         logic [WORD_LOG2-1:0]  byte_sel;
      } pl;
   } paddr_u;

   typedef enum logic [2:0] {
      ST_BOOT,
      ST_IDLE,
      ST_REPLACE,
      ST_REFILL,
      ST_INVALIDATE,
      ST_RELOAD
   } ctrl_state_e;

endpackage

//--- src/way_port_if.sv
`timescale 1ns/1ps

// RAM ports shared by every way; only the write enables are per way
interface way_port_if #(
   parameter int N_WAYS = 2
);

   logic                                   rd_en;
   logic [icache_pkg::SETS_LOG2-1:0]       set_idx;
   logic [icache_pkg::PAYLOAD_AW-1:0]      word_addr;
   logic [N_WAYS-1:0]                      tag_we;
   icache_pkg::tag_entry_t                 tag_wdata;
   logic [N_WAYS-1:0]                      data_we;
   icache_pkg::fetch_word_t                data_wdata;
   // Tag of the request in stage 2
   icache_pkg::tag_t                       lookup_tag;

   modport ctrl (
      output rd_en,
      output set_idx,
      output word_addr,
      output tag_we,
      output tag_wdata,
      output data_we,
      output data_wdata,
      output lookup_tag
   );

   modport way (
      input rd_en,
      input set_idx,
      input word_addr,
      input tag_we,
      input tag_wdata,
      input data_we,
      input data_wdata,
      input lookup_tag
   );

endinterface

//--- src/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl #(
   parameter int N_WAYS = 2
) (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              req_valid,
   output logic                              req_ready,
   input  icache_pkg::paddr_u                req_addr,
   input  logic                              inv_valid,
   input  icache_pkg::paddr_u                inv_addr,
   input  logic                              any_hit,
   output logic                              pipe_ce,
   output logic                              fwd_we,
   output logic                              rsp_valid,
   way_port_if.ctrl                          ways,
   output logic                              ar_valid,
   output logic [icache_pkg::ADDR_W-1:0]     ar_addr,
   input  logic                              ar_ready,
   input  logic                              r_valid,
   input  icache_pkg::fetch_word_t           r_data,
   input  logic                              r_last,
   output logic                              r_ready
);

   localparam int WAY_W = (N_WAYS > 1) ? $clog2(N_WAYS) : 1;

   icache_pkg::ctrl_state_e            state;
   icache_pkg::ctrl_state_e            state_nxt;
   logic [icache_pkg::SETS_LOG2-1:0]   boot_cnt;
   logic [icache_pkg::BEAT_W-1:0]      beat_cnt;
   logic [WAY_W-1:0]                   victim;
   logic                               s1_valid;
   logic                               s2_valid;
   icache_pkg::paddr_u                 s1_addr;
   icache_pkg::paddr_u                 s2_addr;
   logic [icache_pkg::SETS_LOG2-1:0]   inv_set;
   logic                               miss;
   logic                               req_fire;
   logic                               inv_fire;
   logic                               r_fire;
   logic                               reload;

   // Stage 2 missed and everything holds until the line is in
   assign miss      = s2_valid & ~any_hit;
   assign req_ready = (state == icache_pkg::ST_IDLE) & ~miss;
   assign pipe_ce   = req_ready;
   // Invalidate wins over fetch
   assign inv_fire  = inv_valid & req_ready;
   assign req_fire  = req_valid & req_ready & ~inv_valid;
   assign reload    = (state == icache_pkg::ST_RELOAD);

   assign r_ready = (state == icache_pkg::ST_REFILL);
   assign r_fire  = r_valid & r_ready;
   assign fwd_we  = r_fire & (beat_cnt == s2_addr.pl.word[icache_pkg::BEAT_W-1:0]);

   always_comb
   begin
      state_nxt = state;
      case (state)
         icache_pkg::ST_BOOT:
            if (boot_cnt == '1)
               state_nxt = icache_pkg::ST_IDLE;
         icache_pkg::ST_IDLE:
            if (miss)
               state_nxt = icache_pkg::ST_REPLACE;
            else if (inv_valid)
               state_nxt = icache_pkg::ST_INVALIDATE;
         icache_pkg::ST_REPLACE:
            state_nxt = icache_pkg::ST_REFILL;
         icache_pkg::ST_REFILL:
            if (r_fire & r_last)
               state_nxt = icache_pkg::ST_RELOAD;
         default:
            state_nxt = icache_pkg::ST_IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state     <= icache_pkg::ST_BOOT;
         boot_cnt  <= '0;
         beat_cnt  <= '0;
         victim    <= '0;
         s1_valid  <= 1'b0;
         s2_valid  <= 1'b0;
         rsp_valid <= 1'b0;
         ar_valid  <= 1'b0;
      end
      else
      begin
         state     <= state_nxt;
         rsp_valid <= (pipe_ce & s2_valid) | reload;
         if (state == icache_pkg::ST_BOOT)
            boot_cnt <= boot_cnt + 1'b1;
         if (r_fire)
            beat_cnt <= beat_cnt + 1'b1;
         // Round robin that freezes while a line is being replaced
         if (state != icache_pkg::ST_REPLACE && state != icache_pkg::ST_REFILL)
            victim <= victim + 1'b1;
         if (pipe_ce | reload)
         begin
            s1_valid <= req_fire;
            s2_valid <= s1_valid;
         end
         if (state == icache_pkg::ST_REPLACE)
            ar_valid <= 1'b1;
         else if (ar_ready)
            ar_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (req_fire)
         s1_addr <= req_addr;
      if (pipe_ce | reload)
         s2_addr <= s1_addr;
      if (inv_fire)
         inv_set <= inv_addr.lk.set_idx;
      if (state == icache_pkg::ST_REPLACE)
         ar_addr <= {s2_addr.lk.tag, s2_addr.lk.set_idx, {icache_pkg::LINE_LOG2{1'b0}}};
   end

   // RAM addressing by state
   always_comb
   begin
      case (state)
         icache_pkg::ST_BOOT:
            ways.set_idx = boot_cnt;
         icache_pkg::ST_INVALIDATE:
            ways.set_idx = inv_set;
         icache_pkg::ST_REPLACE, icache_pkg::ST_REFILL:
            ways.set_idx = s2_addr.lk.set_idx;
         default:
            ways.set_idx = s1_addr.lk.set_idx;
      endcase
      if (state == icache_pkg::ST_REFILL)
         ways.word_addr = {s2_addr.lk.set_idx, beat_cnt};
      else
         ways.word_addr = s1_addr.pl.word;
   end

   always_comb
   begin
      for (int w = 0; w < N_WAYS; w++)
      begin
         ways.tag_we[w]  = (state == icache_pkg::ST_BOOT) |
                           (state == icache_pkg::ST_INVALIDATE) |
                           ((state == icache_pkg::ST_REPLACE) & (victim == WAY_W'(w)));
         ways.data_we[w] = r_fire & (victim == WAY_W'(w));
      end
   end

   // Boot and invalidate write an empty entry
   assign ways.tag_wdata  = (state == icache_pkg::ST_REPLACE) ?
                            {s2_addr.lk.tag, 1'b1} : '0;
   assign ways.rd_en      = pipe_ce | reload;
   assign ways.data_wdata = r_data;
   assign ways.lookup_tag = s2_addr.lk.tag;

   ar_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
      ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr));

   // Read data only arrives after the address handshake
   r_after_ar_a: assert property (@(posedge clk) disable iff (!rst_n)
      r_fire |-> !ar_valid);

   burst_len_a: assert property (@(posedge clk) disable iff (!rst_n)
      r_fire && r_last |-> beat_cnt == icache_pkg::BEAT_W'(icache_pkg::BEATS - 1));

endmodule

//--- src/icache_way.sv
`timescale 1ns/1ps

module icache_way #(
   parameter int WAY_IDX = 0
) (
   input  logic                    clk,
   way_port_if.way                 port,
   output logic                    hit,
   output icache_pkg::fetch_word_t payload
);

   localparam int SETS  = 1 << icache_pkg::SETS_LOG2;
   localparam int WORDS = 1 << icache_pkg::PAYLOAD_AW;

   icache_pkg::tag_entry_t    tag_ram [SETS];
   icache_pkg::fetch_word_t   data_ram [WORDS];
   icache_pkg::tag_entry_t    tag_q;
   icache_pkg::tag_t          stored_tag;
   logic                      stored_valid;

   // Tag and valid, read together with the payload
   always_ff @(posedge clk)
   begin
      if (port.tag_we[WAY_IDX])
         tag_ram[port.set_idx] <= port.tag_wdata;
      if (port.rd_en)
         tag_q <= tag_ram[port.set_idx];
   end

   // One window per word, written beat by beat on refill
   always_ff @(posedge clk)
   begin
      if (port.data_we[WAY_IDX])
         data_ram[port.word_addr] <= port.data_wdata;
      if (port.rd_en)
         payload <= data_ram[port.word_addr];
   end

   assign stored_tag   = tag_q[icache_pkg::TAG_W:1];
   assign stored_valid = tag_q[0];

   // Compared against the request now in stage 2
   assign hit = stored_valid & (stored_tag == port.lookup_tag);

endmodule

//--- src/icache_sel.sv
`timescale 1ns/1ps

module icache_sel #(
   parameter int N_WAYS = 2
) (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic [N_WAYS-1:0]        hit,
   input  icache_pkg::fetch_word_t  payload [N_WAYS],
   input  icache_pkg::fetch_word_t  r_data,
   input  logic                     pipe_ce,
   input  logic                     fwd_we,
   output logic                     any_hit,
   output icache_pkg::fetch_word_t  rsp_ins
);

   icache_pkg::fetch_word_t hit_word;

   // AND-OR mux, the hit vector is one-hot
   always_comb
   begin
      hit_word = '0;
      for (int w = 0; w < N_WAYS; w++)
      begin
         if (hit[w])
            hit_word = hit_word | payload[w];
      end
   end

   assign any_hit = |hit;

   // Refill beat overrides the lookup result
   always_ff @(posedge clk)
   begin
      if (fwd_we)
         rsp_ins <= r_data;
      else if (pipe_ce)
         rsp_ins <= hit_word;
   end

   // A line never sits in two ways of one set
   hit_onehot_a: assert property (@(posedge clk) disable iff (!rst_n)
      pipe_ce && any_hit |-> $onehot(hit));

endmodule

//--- src/icache_top.sv
`timescale 1ns/1ps

module icache_top #(
   parameter int N_WAYS = 2
) (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           req_valid,
   input  logic [icache_pkg::ADDR_W-1:0]  req_addr,
   output logic                           req_ready,
   input  logic                           inv_valid,
   input  logic [icache_pkg::ADDR_W-1:0]  inv_addr,
   output logic                           rsp_valid,
   output icache_pkg::fetch_word_t        rsp_ins,
   output logic                           ar_valid,
   output logic [icache_pkg::ADDR_W-1:0]  ar_addr,
   input  logic                           ar_ready,
   input  logic                           r_valid,
   input  icache_pkg::fetch_word_t        r_data,
   input  logic                           r_last,
   output logic                           r_ready
);

   logic                      way_hit [N_WAYS];
   logic [N_WAYS-1:0]         hit_vec;
   icache_pkg::fetch_word_t   way_payload [N_WAYS];
   logic                      any_hit;
   logic                      pipe_ce;
   logic                      fwd_we;

   way_port_if #(.N_WAYS(N_WAYS)) ways ();

   icache_ctrl #(.N_WAYS(N_WAYS)) ctrl_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .req_addr  (req_addr),
      .inv_valid (inv_valid),
      .inv_addr  (inv_addr),
      .any_hit   (any_hit),
      .pipe_ce   (pipe_ce),
      .fwd_we    (fwd_we),
      .rsp_valid (rsp_valid),
      .ways      (ways),
      .ar_valid  (ar_valid),
      .ar_addr   (ar_addr),
      .ar_ready  (ar_ready),
      .r_valid   (r_valid),
      .r_data    (r_data),
      .r_last    (r_last),
      .r_ready   (r_ready)
   );

   for (genvar w = 0; w < N_WAYS; w++)
   begin : way_g
      icache_way #(.WAY_IDX(w)) way_i (
         .clk     (clk),
         .port    (ways),
         .hit     (way_hit[w]),
         .payload (way_payload[w])
      );
      assign hit_vec[w] = way_hit[w];
   end

   icache_sel #(.N_WAYS(N_WAYS)) sel_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .hit     (hit_vec),
      .payload (way_payload),
      .r_data  (r_data),
      .pipe_ce (pipe_ce),
      .fwd_we  (fwd_we),
      .any_hit (any_hit),
      .rsp_ins (rsp_ins)
   );

endmodule

//--- bench/tb_icache_mem.sv
`timescale 1ns/1ps

// Read-burst memory with random stalls on both channels
module tb_icache_mem (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        ar_valid,
   input  logic [31:0] ar_addr,
   output logic        ar_ready,
   output logic        r_valid,
   output logic [63:0] r_data,
   output logic        r_last,
   input  logic        r_ready,
   output int          bursts,
   output int          beats
);

   localparam int BURST_LEN = 4;

   logic        run;
   logic        busy;
   logic [31:0] base;
   int          beat;

   // Upper half is the window address, lower half its inverse
   function automatic logic [63:0] window_data(logic [31:0] a);
      return {a, ~a};
   endfunction

   initial
   begin
      ar_ready = 1'b0;
      r_valid  = 1'b0;
      r_last   = 1'b0;
      r_data   = '0;
   end

   always @(posedge clk)
      run <= rst_n;

   // ar_valid and r_ready only move on the rising edge, so the
   // transfer at the next edge is already known here
   always @(negedge clk)
   begin
      ar_ready = 1'b0;
      r_valid  = 1'b0;
      r_last   = 1'b0;
      if (!run)
      begin
         busy   = 1'b0;
         beat   = 0;
         bursts = 0;
         beats  = 0;
      end
      else if (busy)
      begin
         if ($urandom_range(3) != 0)
         begin
            r_valid = 1'b1;
            r_data  = window_data(base + 32'(beat * 8));
            r_last  = (beat == BURST_LEN - 1);
            if (r_ready)
            begin
               beat  = beat + 1;
               beats = beats + 1;
               busy  = (beat != BURST_LEN);
            end
         end
      end
      else if ($urandom_range(3) != 0)
      begin
         ar_ready = 1'b1;
         if (ar_valid)
         begin
            base   = ar_addr;
            beat   = 0;
            busy   = 1'b1;
            bursts = bursts + 1;
         end
      end
   end

endmodule

//--- bench/tb_icache.sv
`timescale 1ns/1ps

module tb_icache;

   localparam int WAIT_MAX = 2000;

   logic        clk;
   logic        rst_n;
   logic        req_valid;
   logic [31:0] req_addr;
   logic        req_ready;
   logic        inv_valid;
   logic [31:0] inv_addr;
   logic        rsp_valid;
   logic [63:0] rsp_ins;
   logic        ar_valid;
   logic [31:0] ar_addr;
   logic        ar_ready;
   logic        r_valid;
   logic [63:0] r_data;
   logic        r_last;
   logic        r_ready;
   int          bursts;
   int          beats;
   // Fetches in flight and the edge each was taken on
   logic [31:0] pending_q [$];
   int          accept_q [$];
   int          cyc;
   int          latency;
   int          ar_rises;
   logic [31:0] line_addr;
   logic        ar_valid_d;

   icache_top #(.N_WAYS(2)) dut_i (.*);

   tb_icache_mem mem_i (.*);

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk)
   begin
      if (!rst_n)
         cyc <= 0;
      else
         cyc <= cyc + 1;
   end

   task automatic abort_run();
      $display("sim failed");
      $fatal(1, "stopped at the first failure");
   endtask

   task automatic report_value(string sig, logic [63:0] exp, logic [63:0] act);
      $display("Error at %0t ns: %s expected %0h, got %0h", $time, sig, exp, act);
      abort_run();
   endtask

   task automatic report_failure(string what);
      $display("%s at %0t ns", what, $time);
      abort_run();
   endtask

   // Window-aligned address above, its inverse below
   function automatic logic [63:0] expected_window(logic [31:0] a);
      logic [31:0] w;
      w = {a[31:3], 3'b000};
      return {w, ~w};
   endfunction

   task automatic wait_ready(string what);
      int n;
      n = 0;
      while (!req_ready)
      begin
         if (n == WAIT_MAX)
            report_failure({"Timeout waiting for req_ready ", what});
         else
         begin
            n++;
            @(negedge clk);
         end
      end
   endtask

   // Leaves req_valid high so fetches can go back to back
   task automatic send_fetch(logic [31:0] addr);
      req_valid = 1'b1;
      req_addr  = addr;
      wait_ready("on a fetch");
      pending_q.push_back(addr);
      accept_q.push_back(cyc + 1);
      @(negedge clk);
   endtask

   task automatic send_inv(logic [31:0] addr);
      inv_valid = 1'b1;
      inv_addr  = addr;
      wait_ready("on an invalidate");
      @(negedge clk);
      inv_valid = 1'b0;
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (pending_q.size() != 0)
      begin
         if (n == WAIT_MAX)
            report_failure("Timeout waiting for outstanding responses");
         else
         begin
            n++;
            @(posedge clk);
         end
      end
      @(negedge clk);
   endtask

   task automatic check_bursts();
      assert (beats == 4 * bursts)
         else report_value("r beat count", 64'(4 * bursts), 64'(beats));
      assert (ar_rises == bursts)
         else report_value("ar_valid count", 64'(bursts), 64'(ar_rises));
   endtask

   // Scoreboard and read address monitor
   always @(negedge clk)
   begin
      logic [63:0] expected;
      logic [31:0] line_exp;
      if (rsp_valid)
      begin
         if (pending_q.size() == 0)
            report_failure("Response with no fetch outstanding");
         else
         begin
            expected = expected_window(pending_q.pop_front());
            latency  = cyc - accept_q.pop_front();
            assert (rsp_ins == expected)
               else report_value("rsp_ins", expected, rsp_ins);
         end
      end
      if (ar_valid && !ar_valid_d)
      begin
         ar_rises  = ar_rises + 1;
         line_addr = ar_addr;
         // The missed fetch is the oldest one still waiting
         if (pending_q.size() == 0)
            report_failure("Read burst with no fetch outstanding");
         else
         begin
            line_exp = pending_q[0] & 32'hffff_ffe0;
            assert (ar_addr == line_exp)
               else report_value("ar_addr", 64'(line_exp), 64'(ar_addr));
         end
      end
      ar_valid_d = ar_valid;
   end

   initial
   begin
      int rises0;
      void'($urandom(32'hf7e806bf));
      ar_rises   = 0;
      ar_valid_d = 1'b0;
      rst_n      = 1'b0;
      req_valid  = 1'b0;
      req_addr   = '0;
      inv_valid  = 1'b0;
      inv_addr   = '0;
      repeat (8) @(negedge clk);
      rst_n = 1'b1;
      assert (req_ready === 1'b0) else report_value("req_ready", 0, req_ready);
      assert (ar_valid === 1'b0) else report_value("ar_valid", 0, ar_valid);
      assert (r_ready === 1'b0) else report_value("r_ready", 0, r_ready);
      assert (rsp_valid === 1'b0) else report_value("rsp_valid", 0, rsp_valid);
      wait_ready("after reset");

      // Cold miss, then another window of the same line
      rises0 = ar_rises;
      send_fetch(32'h0000_1a48);
      req_valid = 1'b0;
      wait_drain();
      assert (ar_rises == rises0 + 1)
         else report_value("ar_valid count", 64'(rises0 + 1), 64'(ar_rises));
      assert (line_addr == 32'h0000_1a40) else report_value("ar_addr", 32'h1a40, line_addr);
      send_fetch(32'h0000_1a58);
      req_valid = 1'b0;
      wait_drain();
      assert (ar_rises == rises0 + 1)
         else report_value("ar_valid count", 64'(rises0 + 1), 64'(ar_rises));
      assert (latency == 2) else report_value("rsp_valid latency", 2, 64'(latency));

      // Dropping the set forces a new burst
      send_inv(32'h0000_1a40);
      send_fetch(32'h0000_1a4c);
      req_valid = 1'b0;
      wait_drain();
      assert (ar_rises == rises0 + 2)
         else report_value("ar_valid count", 64'(rises0 + 2), 64'(ar_rises));

      // Straight-line code over eight lines
      rises0 = ar_rises;
      for (int i = 0; i < 32; i++)
         send_fetch(32'h0002_0000 + 32'(i * 8));
      req_valid = 1'b0;
      wait_drain();
      assert (ar_rises == rises0 + 8)
         else report_value("ar_valid count", 64'(rises0 + 8), 64'(ar_rises));
      check_bursts();

      // Five lines fighting over set 0x15
      for (int i = 0; i < 120; i++)
      begin
         if ($urandom_range(3) == 0)
         begin
            req_valid = 1'b0;
            @(negedge clk);
         end
         send_fetch({16'h0004, 5'($urandom_range(4)), 6'h15,
                     2'($urandom_range(3)), 1'($urandom_range(1)), 2'b00});
      end
      req_valid = 1'b0;
      wait_drain();
      check_bursts();

      $display("sim passed");
      $finish;
   end

endmodule

//--- project.f
src/icache_pkg.sv
src/way_port_if.sv
src/icache_ctrl.sv
src/icache_way.sv
src/icache_sel.sv
src/icache_top.sv
bench/tb_icache_mem.sv
bench/tb_icache.sv

//--- Bender.yml
package:
  name: icache

sources:
  - src/icache_pkg.sv
  - src/way_port_if.sv
  - src/icache_ctrl.sv
  - src/icache_way.sv
  - src/icache_sel.sv
  - src/icache_top.sv
  - target: test
    files:
      - bench/tb_icache_mem.sv
      - bench/tb_icache.sv
